//--- all.f
+incdir+include
design/bpu_pkg.sv
design/bpu_lru.sv
design/bpu_table.sv
design/bpu_fetch_pc.sv
design/bpu_top.sv
dv/bpu_chk.sv
dv/bpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module bpu_tb \
    -Mdir obj_dir -o bpu_sim &&
./obj_dir/bpu_sim || {
    echo "simulation did not complete cleanly"
    exit 1
}

//--- dv/bpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_settings.svh"

module bpu_tb;

    // one table row, its name lives in names[] at the same index
    typedef struct packed {
        logic             upd_valid;
        bpu_pkg::update_t upd;
        logic             rd_valid;
        bpu_pkg::pc_t     rd_pc;
        logic             ready;
        bpu_pkg::fetch_t  exp;
    } step_t;

    localparam int VALID_TIMEOUT = 20;  // cycles after release

    logic             clk;
    logic             rst_n;
    logic             update_valid;
    bpu_pkg::update_t update;
    logic             redirect_valid;
    bpu_pkg::pc_t     redirect_pc;
    logic             fetch_valid;
    bpu_pkg::fetch_t  fetch;
    logic             fetch_ready;

    step_t steps [$];
    string names [$];

    bpu_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .update_valid   (update_valid),
        .update         (update),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .fetch_ready    (fetch_ready)
    );

    always #2 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pc(string name, string what, bpu_pkg::pc_t exp,
                            bpu_pkg::pc_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s %s: expected %h actual %h",
                                name, what, exp, act));
        end
    endtask

    task automatic check_taken(string name, string what, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s %s: expected %b actual %b",
                                name, what, exp, act));
        end
    endtask

    task automatic add_step(string name, logic uv, bpu_pkg::pc_t upc, logic ut,
                            bpu_pkg::pc_t utgt, logic rv, bpu_pkg::pc_t rpc,
                            logic rdy, bpu_pkg::pc_t epc, bpu_pkg::pc_t enext,
                            logic etaken);
        step_t s;
        s.upd_valid      = uv;
        s.upd.pc         = upc;
        s.upd.taken      = ut;
        s.upd.target     = utgt;
        s.rd_valid       = rv;
        s.rd_pc          = rpc;
        s.ready          = rdy;
        s.exp.pc         = epc;
        s.exp.next_pc    = enext;
        s.exp.pred_taken = etaken;
        steps.push_back(s);
        names.push_back(name);
    endtask

    // name | update valid, pc, taken, target | redirect valid, pc | ready
    //      | expected pc, next_pc, pred_taken (before the edge)
    task automatic load_steps();
        add_step("reset_pc",        1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b1, `BPU_RESET_PC, 16'h0104, 1'b0);
        add_step("alloc_taken",     1'b1, 16'h0104, 1'b1, 16'h0200, 1'b0, 16'h0000,
                 1'b0, 16'h0104, 16'h0108, 1'b0);
        add_step("hit_taken",       1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b1, 16'h0104, 16'h0200, 1'b1);
        add_step("follow_target",   1'b1, 16'h0300, 1'b0, 16'h0380, 1'b1, 16'h0300,
                 1'b1, 16'h0200, 16'h0204, 1'b0);
        add_step("alloc_not_taken", 1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b0, 16'h0300, 16'h0304, 1'b0);
        // counter walk on the branch at 0x0400
        add_step("hyst_alloc",      1'b1, 16'h0400, 1'b1, 16'h0480, 1'b1, 16'h0400,
                 1'b0, 16'h0300, 16'h0304, 1'b0);
        add_step("hyst_weak_t",     1'b1, 16'h0400, 1'b0, 16'h0480, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        add_step("hyst_weak_nt",    1'b1, 16'h0400, 1'b1, 16'h0480, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0404, 1'b0);
        add_step("hyst_up_one",     1'b1, 16'h0400, 1'b1, 16'h0480, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        add_step("hyst_strong_t",   1'b1, 16'h0400, 1'b0, 16'h0480, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        add_step("hyst_back_weak",  1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        // fill entries 3..7, fetch stalled meanwhile
        add_step("lru_fill_3",      1'b1, 16'h1000, 1'b1, 16'h1800, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        add_step("lru_fill_4",      1'b1, 16'h1100, 1'b1, 16'h1900, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        add_step("lru_fill_5",      1'b1, 16'h1200, 1'b1, 16'h1a00, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        add_step("lru_fill_6",      1'b1, 16'h1300, 1'b1, 16'h1b00, 1'b0, 16'h0000,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        add_step("lru_fill_7",      1'b1, 16'h1400, 1'b1, 16'h1c00, 1'b1, 16'h0104,
                 1'b0, 16'h0400, 16'h0480, 1'b1);
        // ninth branch takes entry 0 from 0x0104
        add_step("lru_ninth",       1'b1, 16'h1500, 1'b1, 16'h1d00, 1'b0, 16'h0000,
                 1'b0, 16'h0104, 16'h0200, 1'b1);
        add_step("lru_first_gone",  1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b0, 16'h0104, 16'h0108, 1'b0);
        add_step("lru_retouch",     1'b1, 16'h0300, 1'b1, 16'h0380, 1'b1, 16'h0300,
                 1'b0, 16'h0104, 16'h0108, 1'b0);
        add_step("lru_tenth",       1'b1, 16'h1600, 1'b1, 16'h1e00, 1'b1, 16'h0400,
                 1'b0, 16'h0300, 16'h0380, 1'b1);
        add_step("lru_oldest_gone", 1'b0, 16'h0000, 1'b0, 16'h0000, 1'b1, 16'h0300,
                 1'b0, 16'h0400, 16'h0404, 1'b0);
        add_step("lru_survivor",    1'b0, 16'h0000, 1'b0, 16'h0000, 1'b1, 16'h1500,
                 1'b0, 16'h0300, 16'h0380, 1'b1);
        add_step("lru_ninth_hit",   1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b1, 16'h1500, 16'h1d00, 1'b1);
        // back-pressure, then a redirect while stalled
        add_step("stall_a",         1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b0, 16'h1d00, 16'h1d04, 1'b0);
        add_step("stall_b",         1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b0, 16'h1d00, 16'h1d04, 1'b0);
        add_step("stall_c",         1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b0, 16'h1d00, 16'h1d04, 1'b0);
        add_step("redirect_stall",  1'b0, 16'h0000, 1'b0, 16'h0000, 1'b1, 16'h2000,
                 1'b0, 16'h1d00, 16'h1d04, 1'b0);
        add_step("redirect_done",   1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b1, 16'h2000, 16'h2004, 1'b0);
        add_step("seq_step",        1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b1, 16'h2004, 16'h2008, 1'b0);
        add_step("seq_hold",        1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 16'h0000,
                 1'b0, 16'h2008, 16'h200c, 1'b0);
    endtask

    task automatic drive_step(step_t s);
        update_valid   = s.upd_valid;
        update         = s.upd;
        redirect_valid = s.rd_valid;
        redirect_pc    = s.rd_pc;
        fetch_ready    = s.ready;
    endtask

    task automatic wait_fetch_valid();
        int cycles;
        cycles = 0;
        while (!fetch_valid && cycles < VALID_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!fetch_valid) begin
            abort_run($sformatf("fetch_valid did not rise within %0d cycles of reset release",
                                VALID_TIMEOUT));
        end
    endtask

    initial begin
        int k;
        clk            = 1'b0;
        rst_n          = 1'b0;
        update_valid   = 1'b0;
        update         = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        fetch_ready    = 1'b0;
        load_steps();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait_fetch_valid();

        for (k = 0; k < steps.size(); k++) begin
            drive_step(steps[k]);
            #1;     // settle combinational lookup
            check_taken(names[k], "fetch_valid", 1'b1, fetch_valid);
            check_pc(names[k], "pc", steps[k].exp.pc, fetch.pc);
            check_pc(names[k], "next_pc", steps[k].exp.next_pc, fetch.next_pc);
            check_taken(names[k], "pred_taken", steps[k].exp.pred_taken,
                        fetch.pred_taken);
            @(negedge clk);
        end

        update_valid   = 1'b0;
        redirect_valid = 1'b0;
        fetch_ready    = 1'b0;
        @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/bpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_chk #(
    parameter bit TABLE_SIDE = 1'b0     // set on the table instance
) (
    input wire                       clk,
    input wire                       rst_n,
    input wire bpu_pkg::entry_mask_t victim_mask,
    input wire                       fetch_valid,
    input wire                       fetch_ready,
    input wire                       redirect_valid,
    input wire bpu_pkg::pc_t         redirect_pc,
    input wire bpu_pkg::fetch_t      fetch
);

    generate
        if (TABLE_SIDE) begin : g_table
            // the age matrix always names exactly one oldest entry
            victim_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot(victim_mask))
                else $error("victim_mask not one-hot: %b", victim_mask);
        end else begin : g_fetch
            // stalled fetch keeps its address even while the table retrains
            stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
                fetch_valid && !fetch_ready && !redirect_valid |=> $stable(fetch.pc))
                else $error("fetch.pc moved under back-pressure");

            redirect_lands: assert property (@(posedge clk) disable iff (!rst_n)
                redirect_valid |=> fetch.pc == $past(redirect_pc))
                else $error("fetch.pc did not take the redirect address");

            valid_sticky: assert property (@(posedge clk) disable iff (!rst_n)
                fetch_valid |=> fetch_valid)
                else $error("fetch_valid fell after rising");
        end
    endgenerate

endmodule

// fetch ports unused on the table side
bind bpu_table bpu_chk #(.TABLE_SIDE(1'b1)) tbl_chk0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .victim_mask    (victim_mask),
    .fetch_valid    (1'b0),
    .fetch_ready    (1'b0),
    .redirect_valid (1'b0),
    .redirect_pc    ('0),
    .fetch          ('0)
);

bind bpu_fetch_pc bpu_chk #(.TABLE_SIDE(1'b0)) fpc_chk0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .victim_mask    ('0),   // unused on the fetch side
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fetch          (fetch)
);

`default_nettype wire

//--- design/bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   update_valid,
    input  wire bpu_pkg::update_t update,
    input  wire                   redirect_valid,
    input  wire bpu_pkg::pc_t     redirect_pc,
    output logic                  fetch_valid,
    output bpu_pkg::fetch_t       fetch,
    input  wire                   fetch_ready
);

    bpu_pkg::pc_t   lookup_pc;
    bpu_pkg::pred_t pred;   // same-cycle answer for lookup_pc

    bpu_fetch_pc fpc0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .pred           (pred),
        .lookup_pc      (lookup_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready),
        .fetch          (fetch)
    );

    bpu_table tbl0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_pc    (lookup_pc),
        .pred         (pred),
        .update_valid (update_valid),
        .update       (update)
    );

endmodule

`default_nettype wire

//--- design/bpu_fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_settings.svh"

module bpu_fetch_pc (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire bpu_pkg::pred_t pred,
    output bpu_pkg::pc_t        lookup_pc,
    input  wire                 redirect_valid,
    input  wire bpu_pkg::pc_t   redirect_pc,
    output logic                fetch_valid,
    input  wire                 fetch_ready,
    output bpu_pkg::fetch_t     fetch
);

    logic         arm_q;    // first edge after release seen
    logic         valid_q;
    bpu_pkg::pc_t pc_q;
    bpu_pkg::pc_t next_pc;
    logic         pred_taken;
    logic         xfer;

    // only a hit with the counter msb set turns the flow
    assign pred_taken = pred.hit && pred.ctr[1];
    assign next_pc    = pred_taken ? pred.target : pc_q + bpu_pkg::pc_t'(4);

    assign lookup_pc   = pc_q;
    assign fetch_valid = valid_q;
    assign xfer        = valid_q && fetch_ready;

    always_comb begin
        fetch.pc         = pc_q;
        fetch.next_pc    = next_pc;
        fetch.pred_taken = pred_taken;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arm_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            arm_q   <= 1'b1;
            valid_q <= valid_q | arm_q;     // sticky once up
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `BPU_RESET_PC;
        end else if (redirect_valid) begin
            pc_q <= redirect_pc;    // redirect beats prediction and stall
        end else if (xfer) begin
            pc_q <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- design/bpu_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_settings.svh"

module bpu_table (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire bpu_pkg::pc_t     lookup_pc,
    output bpu_pkg::pred_t        pred,
    input  wire                   update_valid,
    input  wire bpu_pkg::update_t update
);

    bpu_pkg::entry_mask_t valid_q;
    bpu_pkg::pc_t         tag_q    [`BPU_ENTRIES];
    bpu_pkg::pc_t         target_q [`BPU_ENTRIES];
    bpu_pkg::ctr_t        ctr_q    [`BPU_ENTRIES];

    bpu_pkg::entry_mask_t look_hit;
    bpu_pkg::entry_mask_t upd_hit;
    logic                 upd_any;
    bpu_pkg::entry_mask_t victim_mask;
    bpu_pkg::entry_mask_t touch_mask;

    // heap layout, leaves at N..2N-1, root at 1
    bpu_pkg::pred_t or_node [1:2*`BPU_ENTRIES-1];

    // 2-bit saturating step
    function automatic bpu_pkg::ctr_t ctr_next(bpu_pkg::ctr_t c, logic taken);
        bpu_pkg::ctr_t n;
        n = c;
        if (taken && c != 2'b11) begin
            n = c + 2'd1;
        end else if (!taken && c != 2'b00) begin
            n = c - 2'd1;
        end
        return n;
    endfunction

    // tags are full PCs, no aliasing
    always_comb begin
        for (int i = 0; i < `BPU_ENTRIES; i++) begin
            look_hit[i] = valid_q[i] && (tag_q[i] == lookup_pc);
            upd_hit[i]  = valid_q[i] && (tag_q[i] == update.pc);
        end
    end

    always_comb begin
        int n;
        for (int i = 0; i < `BPU_ENTRIES; i++) begin
            or_node[`BPU_ENTRIES + i] = '0;   // masked off unless hit
            if (look_hit[i]) begin
                or_node[`BPU_ENTRIES + i].hit    = 1'b1;
                or_node[`BPU_ENTRIES + i].ctr    = ctr_q[i];
                or_node[`BPU_ENTRIES + i].target = target_q[i];
            end
        end
        // one level per index bit, bottom up
        for (int lvl = `BPU_IDX_BITS - 1; lvl >= 0; lvl--) begin
            for (int j = 0; j < (1 << lvl); j++) begin
                n = (1 << lvl) + j;
                or_node[n] = or_node[2*n] | or_node[2*n + 1];
            end
        end
    end

    assign pred = or_node[1];

    // hit retrains in place, miss takes the oldest slot
    assign upd_any    = |upd_hit;
    assign touch_mask = upd_any ? upd_hit : victim_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (update_valid) begin
            valid_q <= valid_q | touch_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid) begin
            for (int i = 0; i < `BPU_ENTRIES; i++) begin
                if (touch_mask[i]) begin
                    tag_q[i]    <= update.pc;
                    target_q[i] <= update.target;
                    if (upd_any) begin
                        ctr_q[i] <= ctr_next(ctr_q[i], update.taken);
                    end else begin
                        // new entries start weak
                        ctr_q[i] <= update.taken ? 2'b10 : 2'b01;
                    end
                end
            end
        end
    end

    bpu_lru lru0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .touch_valid (update_valid),
        .touch_mask  (touch_mask),
        .victim_mask (victim_mask)
    );

endmodule

`default_nettype wire

//--- design/bpu_lru.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_settings.svh"

module bpu_lru (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       touch_valid,
    input  wire bpu_pkg::entry_mask_t touch_mask,
    output bpu_pkg::entry_mask_t      victim_mask
);

    // row i, bit j set: entry j was used after entry i
    // the diagonal always stays set, so the oldest entry has a full row
    bpu_pkg::entry_mask_t age_q [`BPU_ENTRIES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // entry 0 oldest, entry 7 newest
            for (int i = 0; i < `BPU_ENTRIES; i++) begin
                for (int j = 0; j < `BPU_ENTRIES; j++) begin
                    age_q[i][j] <= (i <= j);
                end
            end
        end else if (touch_valid) begin
            for (int i = 0; i < `BPU_ENTRIES; i++) begin
                if (touch_mask[i]) begin
                    age_q[i] <= touch_mask;     // newest, only own bit left
                end else begin
                    age_q[i] <= age_q[i] | touch_mask;  // everyone else ages
                end
            end
        end
    end

    // full row means nothing older than this entry
    always_comb begin
        for (int i = 0; i < `BPU_ENTRIES; i++) begin
            victim_mask[i] = &age_q[i];
        end
    end

endmodule

`default_nettype wire

//--- design/bpu_pkg.sv
`default_nettype none

`include "bpu_settings.svh"

package bpu_pkg;

    typedef logic [`BPU_PC_BITS-1:0] pc_t;     // byte address

    // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
    typedef logic [1:0] ctr_t;

    typedef logic [`BPU_ENTRIES-1:0] entry_mask_t;  // one-hot or empty

    // lookup result
    typedef struct packed {
        logic hit;
        ctr_t ctr;
        pc_t  target;
    } pred_t;

    // resolved branch from execute
    typedef struct packed {
        pc_t  pc;
        logic taken;
        pc_t  target;
    } update_t;

    typedef struct packed {
        pc_t  pc;
        pc_t  next_pc;
        logic pred_taken;
    } fetch_t;

endpackage

`default_nettype wire

//--- include/bpu_settings.svh
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// fetch address width in bits
`define BPU_PC_BITS 16

// table depth, fully associative
`define BPU_ENTRIES 8

// log2 of the table depth
`define BPU_IDX_BITS 3

// first fetch address after reset
`define BPU_RESET_PC 16'h0100

`endif
